// File: include/ulpi_rxcmd.svh
`ifndef ULPI_RXCMD_SVH
`define ULPI_RXCMD_SVH

// Line state of D+ and D-
`define ULPI_RXCMD_LINESTATE 1:0
// RxEvent bit 4 is set for both RxActive and RxError
`define ULPI_RXCMD_RXACTIVE 4
// Set together with RxActive when the PHY saw a receive error
`define ULPI_RXCMD_RXERROR 5

`endif

// File: src/usb_pkg.sv
package usb_pkg;

  // Byte as seen on the ULPI data bus and the bulk OUT stream
  typedef logic [7:0] usb_byte_t;

  // Low nibble of a PID byte, the high nibble carries its complement
  typedef logic [3:0] usb_pid_t;

  // CRC16 shift register, LSB first like the bus bit order
  typedef logic [15:0] crc16_t;

  // Data PIDs
  localparam usb_pid_t PID_DATA0 = 4'b0011;
  localparam usb_pid_t PID_DATA1 = 4'b1011;

  // x^16 + x^15 + x^2 + 1, bit reversed for LSB-first shifting
  localparam crc16_t CRC16_POLY = 16'hA001;

  // Register value left once the inverted CRC bytes have been shifted in
  // after the payload (0x800D in MSB-first notation)
  localparam crc16_t CRC16_RESIDUE = 16'hB001;

endpackage

// File: src/ulpi_reset.sv
`timescale 1ns/1ps
module ulpi_reset #(
  parameter integer PHY_RESET_CYCLES = 8
) (
  input  logic ulpi_clk,
  input  logic rst_n_i,
  output logic ulpi_rst_o,
  output logic usb_reset_o
);

  localparam integer CW = $clog2(PHY_RESET_CYCLES + 1);

  logic [CW-1:0] cnt_q;
  logic          phy_rst_q;
  logic [1:0]    sync_q;

  // PHY reset pulse, counted from the release of rst_n_i
  always_ff @(posedge ulpi_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q     <= '0;
      phy_rst_q <= 1'b1;
    end else if (phy_rst_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == CW'(PHY_RESET_CYCLES - 1)) phy_rst_q <= 1'b0;
    end
  end

  // Core stays in reset two more cycles
  always_ff @(posedge ulpi_clk or negedge rst_n_i) begin
    if (!rst_n_i) sync_q <= 2'b11;
    else sync_q <= {sync_q[0], phy_rst_q};
  end

  assign ulpi_rst_o  = phy_rst_q;
  assign usb_reset_o = sync_q[1];

endmodule

// File: src/ulpi_rx.sv
`timescale 1ns/1ps
`include "ulpi_rxcmd.svh"
module ulpi_rx (
  input  logic               ulpi_clk,
  input  logic               usb_reset_i,
  input  logic               dir_i,
  input  logic               nxt_i,
  input  usb_pkg::usb_byte_t data_i,
  output usb_pkg::usb_byte_t rx_byte_o,
  output logic               rx_valid_o,
  output logic               rx_start_o,
  output logic               rx_end_o
);

  logic               dir_q;
  logic               active_q;  // RxActive as last reported
  logic               first_q;   // Next byte is the PID
  logic               bus_w;
  logic               rxcmd_w;
  usb_pkg::usb_byte_t byte_q;
  logic               valid_q;
  logic               start_q;
  logic               end_q;

  assign bus_w   = dir_i && dir_q;  // PHY owns the bus, turnaround excluded
  assign rxcmd_w = bus_w && !nxt_i;

  always_ff @(posedge ulpi_clk) begin
    if (usb_reset_i) begin
      dir_q    <= 1'b0;
      active_q <= 1'b0;
      first_q  <= 1'b0;
      valid_q  <= 1'b0;
      start_q  <= 1'b0;
      end_q    <= 1'b0;
    end else begin
      dir_q   <= dir_i;
      valid_q <= 1'b0;
      start_q <= 1'b0;
      end_q   <= 1'b0;
      if (bus_w && nxt_i && active_q) begin
        valid_q <= 1'b1;
        start_q <= first_q;
        first_q <= 1'b0;
      end else if (rxcmd_w) begin
        if (data_i[`ULPI_RXCMD_RXACTIVE]) begin
          first_q  <= first_q || !active_q;  // Rising RxActive opens a packet
          active_q <= 1'b1;
        end else begin
          end_q    <= active_q;
          active_q <= 1'b0;
        end
      end else if (!dir_i && dir_q && active_q) begin
        // PHY dropped dir mid packet
        end_q    <= 1'b1;
        active_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (bus_w && nxt_i) byte_q <= data_i;
  end

  assign rx_byte_o  = byte_q;
  assign rx_valid_o = valid_q;
  assign rx_start_o = start_q;
  assign rx_end_o   = end_q;

endmodule

// File: src/usb_pid_check.sv
`timescale 1ns/1ps
module usb_pid_check (
  input  logic               ulpi_clk,
  input  logic               usb_reset_i,
  input  usb_pkg::usb_byte_t rx_byte_i,
  input  logic               rx_valid_i,
  input  logic               rx_start_i,
  input  logic               rx_end_i,
  output logic               pid_data_o
);

  usb_pkg::usb_byte_t pid_byte_q;
  usb_pkg::usb_pid_t  pid_code_w;
  logic               got_pid_q;
  logic               pid_ok_w;
  logic               pid_data_q;

  assign pid_code_w = pid_byte_q[3:0];
  assign pid_ok_w   = (pid_byte_q[7:4] == ~pid_code_w) &&
                      (pid_code_w == usb_pkg::PID_DATA0 || pid_code_w == usb_pkg::PID_DATA1);

  always_ff @(posedge ulpi_clk) begin
    if (usb_reset_i) begin
      got_pid_q  <= 1'b0;
      pid_data_q <= 1'b0;
    end else if (rx_valid_i && rx_start_i) begin
      got_pid_q  <= 1'b1;
      pid_data_q <= 1'b0;  // Verdict cleared for the new packet
    end else if (rx_end_i) begin
      got_pid_q  <= 1'b0;
      pid_data_q <= got_pid_q && pid_ok_w;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (rx_valid_i && rx_start_i) pid_byte_q <= rx_byte_i;
  end

  assign pid_data_o = pid_data_q;

endmodule

// File: src/usb_crc16.sv
`timescale 1ns/1ps
module usb_crc16 (
  input  logic               ulpi_clk,
  input  logic               usb_reset_i,
  input  usb_pkg::usb_byte_t rx_byte_i,
  input  logic               rx_valid_i,
  input  logic               rx_start_i,
  input  logic               rx_end_i,
  output logic               crc_done_o,
  output logic               crc_ok_o
);

  usb_pkg::crc16_t crc_q;
  logic            done_q;
  logic            ok_q;

  // One byte, LSB first
  function automatic usb_pkg::crc16_t crc16_byte(input usb_pkg::crc16_t crc,
                                                 input usb_pkg::usb_byte_t data);
    usb_pkg::crc16_t c;
    int              i;
    c = crc;
    for (i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) c = (c >> 1) ^ usb_pkg::CRC16_POLY;
      else c = c >> 1;
    end
    return c;
  endfunction

  always_ff @(posedge ulpi_clk) begin
    if (usb_reset_i) begin
      crc_q  <= '1;
      done_q <= 1'b0;
      ok_q   <= 1'b0;
    end else begin
      done_q <= rx_end_i;
      if (rx_valid_i && rx_start_i) crc_q <= '1;  // PID is not covered
      else if (rx_valid_i) crc_q <= crc16_byte(crc_q, rx_byte_i);
      if (rx_end_i) ok_q <= (crc_q == usb_pkg::CRC16_RESIDUE);
    end
  end

  assign crc_done_o = done_q;
  assign crc_ok_o   = ok_q;

endmodule

// File: src/usb_bulk_out.sv
`timescale 1ns/1ps
module usb_bulk_out #(
  parameter integer PACKET_FIFO_DEPTH = 256,
  parameter integer MAX_PACKET_LENGTH = 64
) (
  input  logic               ulpi_clk,
  input  logic               usb_reset_i,
  input  usb_pkg::usb_byte_t rx_byte_i,
  input  logic               rx_valid_i,
  input  logic               rx_start_i,
  input  logic               pid_data_i,
  input  logic               crc_done_i,
  input  logic               crc_ok_i,
  output logic               blko_tvalid_o,
  input  logic               blko_tready_i,
  output logic               blko_tlast_o,
  output usb_pkg::usb_byte_t blko_tdata_o,
  output logic               crc_error_o
);

  localparam integer AW = $clog2(PACKET_FIFO_DEPTH);
  localparam integer LW = $clog2(PACKET_FIFO_DEPTH + MAX_PACKET_LENGTH + 3);

  usb_pkg::usb_byte_t mem [PACKET_FIFO_DEPTH];
  logic [AW:0]        eq_mem [4];  // End addresses of committed packets
  logic [AW:0]        wr_ptr_q, base_q, rd_ptr_q, end_w, rd_next_w;
  logic [2:0]         eq_wr_q, eq_rd_q;
  logic [LW-1:0]      len_q;  // Bytes after the PID, CRC included
  logic               ovf_q, full_w, eq_full_w, wr_en_w, commit_w, load_w, last_w;
  usb_pkg::usb_byte_t data_q;
  logic               valid_q, last_q;

  assign full_w    = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);
  assign eq_full_w = (eq_wr_q - eq_rd_q) == 3'd4;
  assign wr_en_w   = rx_valid_i && !rx_start_i && !ovf_q && !full_w;
  assign end_w     = wr_ptr_q - 2'd2;  // Strip the CRC bytes
  assign commit_w  = crc_done_i && pid_data_i && crc_ok_i && !ovf_q && !eq_full_w &&
                     len_q >= LW'(3) && len_q <= LW'(MAX_PACKET_LENGTH + 2);
  assign rd_next_w = rd_ptr_q + 1'b1;
  assign last_w    = rd_next_w == eq_mem[eq_rd_q[1:0]];
  assign load_w    = (rd_ptr_q != base_q) && (!valid_q || blko_tready_i);

  // Speculative write side
  always_ff @(posedge ulpi_clk) begin
    if (usb_reset_i) begin
      wr_ptr_q <= '0;
      base_q   <= '0;
      len_q    <= '0;
      ovf_q    <= 1'b0;
      eq_wr_q  <= '0;
    end else begin
      if (rx_valid_i && rx_start_i) begin
        wr_ptr_q <= base_q;
        len_q    <= '0;
        ovf_q    <= 1'b0;
      end else if (wr_en_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        len_q    <= len_q + 1'b1;
      end else if (rx_valid_i) begin
        ovf_q <= 1'b1;  // Buffer full, packet is lost
      end
      if (commit_w) begin
        wr_ptr_q <= end_w;
        base_q   <= end_w;
        eq_wr_q  <= eq_wr_q + 1'b1;
      end else if (crc_done_i) begin
        wr_ptr_q <= base_q;  // Rewind
      end
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (wr_en_w) mem[wr_ptr_q[AW-1:0]] <= rx_byte_i;
    if (commit_w) eq_mem[eq_wr_q[1:0]] <= end_w;
  end

  // Output register, refilled when empty or accepted
  always_ff @(posedge ulpi_clk) begin
    if (usb_reset_i) begin
      rd_ptr_q <= '0;
      eq_rd_q  <= '0;
      valid_q  <= 1'b0;
      last_q   <= 1'b0;
    end else if (load_w) begin
      rd_ptr_q <= rd_next_w;
      valid_q  <= 1'b1;
      last_q   <= last_w;
      if (last_w) eq_rd_q <= eq_rd_q + 1'b1;
    end else if (blko_tready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (load_w) data_q <= mem[rd_ptr_q[AW-1:0]];
  end

  assign blko_tvalid_o = valid_q;
  assign blko_tlast_o  = last_q;
  assign blko_tdata_o  = data_q;
  assign crc_error_o   = crc_done_i && pid_data_i && !crc_ok_i;

endmodule

// File: src/usb_ulpi_core.sv
`timescale 1ns/1ps
module usb_ulpi_core #(
  parameter integer PHY_RESET_CYCLES  = 8,
  parameter integer PACKET_FIFO_DEPTH = 256,
  parameter integer MAX_PACKET_LENGTH = 64
) (
  input  logic               ulpi_clk,
  input  logic               rst_n_i,
  input  logic               ulpi_dir_i,
  input  logic               ulpi_nxt_i,
  input  usb_pkg::usb_byte_t ulpi_data_i,
  output logic               ulpi_rst_o,
  output logic               usb_reset_o,
  output logic               blko_tvalid_o,
  input  logic               blko_tready_i,
  output logic               blko_tlast_o,
  output usb_pkg::usb_byte_t blko_tdata_o,
  output logic               crc_error_o
);

  logic               usb_reset;
  usb_pkg::usb_byte_t rx_byte;
  logic               rx_valid, rx_start, rx_end;
  logic               pid_data, crc_done, crc_ok;

  ulpi_reset #(
    .PHY_RESET_CYCLES(PHY_RESET_CYCLES)
  ) u_reset (
    .ulpi_clk   (ulpi_clk),
    .rst_n_i    (rst_n_i),
    .ulpi_rst_o (ulpi_rst_o),
    .usb_reset_o(usb_reset)  // Active high, synchronous to ulpi_clk
  );

  ulpi_rx u_rx (
    .ulpi_clk   (ulpi_clk),
    .usb_reset_i(usb_reset),
    .dir_i      (ulpi_dir_i),
    .nxt_i      (ulpi_nxt_i),
    .data_i     (ulpi_data_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid),
    .rx_start_o (rx_start),
    .rx_end_o   (rx_end)
  );

  usb_pid_check u_pid (
    .ulpi_clk   (ulpi_clk),
    .usb_reset_i(usb_reset),
    .rx_byte_i  (rx_byte),
    .rx_valid_i (rx_valid),
    .rx_start_i (rx_start),
    .rx_end_i   (rx_end),
    .pid_data_o (pid_data)
  );

  usb_crc16 u_crc (
    .ulpi_clk   (ulpi_clk),
    .usb_reset_i(usb_reset),
    .rx_byte_i  (rx_byte),
    .rx_valid_i (rx_valid),
    .rx_start_i (rx_start),
    .rx_end_i   (rx_end),
    .crc_done_o (crc_done),
    .crc_ok_o   (crc_ok)
  );

  usb_bulk_out #(
    .PACKET_FIFO_DEPTH(PACKET_FIFO_DEPTH),
    .MAX_PACKET_LENGTH(MAX_PACKET_LENGTH)
  ) u_bulk_out (
    .ulpi_clk     (ulpi_clk),
    .usb_reset_i  (usb_reset),
    .rx_byte_i    (rx_byte),
    .rx_valid_i   (rx_valid),
    .rx_start_i   (rx_start),
    .pid_data_i   (pid_data),
    .crc_done_i   (crc_done),
    .crc_ok_i     (crc_ok),
    .blko_tvalid_o(blko_tvalid_o),  // Bulk OUT stream
    .blko_tready_i(blko_tready_i),
    .blko_tlast_o (blko_tlast_o),
    .blko_tdata_o (blko_tdata_o),
    .crc_error_o  (crc_error_o)
  );

  assign usb_reset_o = usb_reset;

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps
module tb_clock #(
  parameter integer PERIOD_NS = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // Starts low, first rising edge after half a period
  end

endmodule

// File: tests/usb_ulpi_core_sva.sv
`timescale 1ns/1ps
module usb_ulpi_core_sva (
  input logic               ulpi_clk,
  input logic               rst_n_i,
  input logic               usb_reset_i,
  input logic               tvalid_i,
  input logic               tready_i,
  input logic               tlast_i,
  input usb_pkg::usb_byte_t tdata_i,
  input logic               crc_error_i
);

  // A stalled sink sees the same word on the next cycle
  stream_hold_a : assert property (@(posedge ulpi_clk) disable iff (!rst_n_i)
    tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i) && $stable(tlast_i))
    else $error("blko stream changed while tready was low");

  crc_error_pulse_a : assert property (@(posedge ulpi_clk) disable iff (!rst_n_i)
    crc_error_i |=> !crc_error_i)
    else $error("crc_error_o stayed high for two cycles");

  // Core reset keeps every output quiet
  reset_idle_a : assert property (@(posedge ulpi_clk) disable iff (!rst_n_i)
    usb_reset_i |-> !tvalid_i && !crc_error_i)
    else $error("output active while usb_reset_o is high");

endmodule

bind usb_ulpi_core usb_ulpi_core_sva i_usb_ulpi_core_sva (
  .ulpi_clk   (ulpi_clk),
  .rst_n_i    (rst_n_i),
  .usb_reset_i(usb_reset_o),
  .tvalid_i   (blko_tvalid_o),
  .tready_i   (blko_tready_i),
  .tlast_i    (blko_tlast_o),
  .tdata_i    (blko_tdata_o),
  .crc_error_i(crc_error_o)
);

// File: tests/usb_ulpi_core_tb.sv
`timescale 1ns/1ps
`include "ulpi_rxcmd.svh"
module usb_ulpi_core_tb;

  localparam integer PHY_RESET_CYCLES = 8;
  localparam integer MAX_LEN          = 64;
  localparam integer RESET_CYCLES     = 5;
  localparam integer SEED             = 90552;
  localparam integer N_GOOD           = 8;
  localparam integer N_CRC_BAD        = 3;
  localparam integer N_IGNORED        = 4;
  localparam integer N_BP             = 10;
  localparam integer N_LONG           = 2;
  localparam integer N_PACKETS        = N_GOOD + N_CRC_BAD + N_IGNORED + N_BP + N_LONG;
  localparam integer WATCHDOG_CYCLES  = 200 * N_PACKETS + RESET_CYCLES + PHY_RESET_CYCLES + 2;

  logic               ulpi_clk;
  logic               rst_n_i;
  logic               ulpi_dir_i;
  logic               ulpi_nxt_i;
  usb_pkg::usb_byte_t ulpi_data_i;
  logic               blko_tready_i = 1'b0;
  logic               ulpi_rst_o;
  logic               usb_reset_o;
  logic               blko_tvalid_o;
  logic               blko_tlast_o;
  usb_pkg::usb_byte_t blko_tdata_o;
  logic               crc_error_o;

  usb_pkg::usb_byte_t tx_q[$];  // PID, payload and CRC as sent on the bus
  logic [8:0]         exp_q[$];  // Scoreboard of {tlast, tdata}
  logic [8:0]         exp_word;
  logic               bp_mode = 1'b0;
  int check_errors, stream_errors, crc_err_cnt, bad_crc_sent;
  int pkts_sent, pkts_expected, pkts_received, bytes_received;

  tb_clock #(.PERIOD_NS(100)) i_tb_clock (.clk_o(ulpi_clk));

  usb_ulpi_core #(
    .PHY_RESET_CYCLES (PHY_RESET_CYCLES),
    .PACKET_FIFO_DEPTH(256),
    .MAX_PACKET_LENGTH(MAX_LEN)
  ) i_usb_ulpi_core (
    .ulpi_clk     (ulpi_clk),
    .rst_n_i      (rst_n_i),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (ulpi_data_i),
    .ulpi_rst_o   (ulpi_rst_o),
    .usb_reset_o  (usb_reset_o),
    .blko_tvalid_o(blko_tvalid_o),
    .blko_tready_i(blko_tready_i),
    .blko_tlast_o (blko_tlast_o),
    .blko_tdata_o (blko_tdata_o),
    .crc_error_o  (crc_error_o)
  );

  function automatic usb_pkg::usb_byte_t pid_byte(input usb_pkg::usb_pid_t code);
    return {~code, code};
  endfunction

  function automatic usb_pkg::usb_byte_t rxcmd_byte(input logic active);
    usb_pkg::usb_byte_t b;
    b = '0;
    b[`ULPI_RXCMD_LINESTATE] = 2'b01;  // J state
    b[`ULPI_RXCMD_RXACTIVE]  = active;
    b[`ULPI_RXCMD_RXERROR]   = 1'b0;
    return b;
  endfunction

  // Reflected CRC16 over tx_q[first..last] with the LSB of each byte first
  function automatic usb_pkg::crc16_t crc16_over(input int first, input int last);
    usb_pkg::crc16_t crc;
    logic            fb;
    int              i;
    int              b;
    crc = 16'hFFFF;
    for (i = first; i <= last; i++) begin
      for (b = 0; b < 8; b++) begin
        fb  = crc[0] ^ tx_q[i][b];
        crc = {1'b0, crc[15:1]};
        if (fb) crc = crc ^ usb_pkg::CRC16_POLY;
      end
    end
    return crc;
  endfunction

  task automatic report_counts();
    $display("Packets %0d sent, %0d received, %0d bytes, crc errors %0d of %0d, errors %0d",
             pkts_sent, pkts_received, bytes_received, crc_err_cnt, bad_crc_sent,
             check_errors + stream_errors);
  endtask

  task automatic check_reset_sequence();
    int rst_cycles;
    int gap_cycles;
    rst_cycles = 0;
    gap_cycles = 0;
    @(negedge ulpi_clk);
    while (ulpi_rst_o || usb_reset_o) begin
      if (ulpi_rst_o) rst_cycles++;
      else gap_cycles++;  // PHY out of reset while the core is still held
      assert (!blko_tvalid_o && !crc_error_o) else begin
        check_errors++;
        $display("error at %0t: output active during reset", $time);
      end
      @(negedge ulpi_clk);
    end
    assert (rst_cycles == PHY_RESET_CYCLES) else begin
      check_errors++;
      $display("error at %0t: ulpi_rst_o high for %0d cycles", $time, rst_cycles);
    end
    assert (gap_cycles == 2) else begin
      check_errors++;
      $display("error at %0t: usb_reset_o fell %0d cycles after ulpi_rst_o", $time, gap_cycles);
    end
  endtask

  // Turnaround, RX CMD, bytes with random RX CMD gaps, closing RX CMD
  task automatic phy_send();
    int i;
    @(posedge ulpi_clk);
    ulpi_dir_i <= 1'b1;
    ulpi_nxt_i <= 1'b0;
    @(posedge ulpi_clk);
    ulpi_data_i <= rxcmd_byte(1'b1);
    for (i = 0; i < tx_q.size(); i++) begin
      if ($urandom_range(0, 3) == 0) begin
        @(posedge ulpi_clk);
        ulpi_nxt_i  <= 1'b0;
        ulpi_data_i <= rxcmd_byte(1'b1);
      end
      @(posedge ulpi_clk);
      ulpi_nxt_i  <= 1'b1;
      ulpi_data_i <= tx_q[i];
    end
    @(posedge ulpi_clk);
    ulpi_nxt_i  <= 1'b0;
    ulpi_data_i <= rxcmd_byte(1'b0);
    @(posedge ulpi_clk);
    ulpi_dir_i  <= 1'b0;
    ulpi_data_i <= '0;
    repeat (3) @(posedge ulpi_clk);  // Verdict lands three cycles after the closing RX CMD
  endtask

  task automatic run_packet(input usb_pkg::usb_byte_t pid, input int len, input logic corrupt);
    usb_pkg::crc16_t crc;
    logic            is_data;
    logic            expect_out;
    int              errs_before;
    int              i;
    is_data    = (pid[7:4] == ~pid[3:0]) &&
                 (pid[3:0] == usb_pkg::PID_DATA0 || pid[3:0] == usb_pkg::PID_DATA1);
    expect_out = is_data && !corrupt && len >= 1 && len <= MAX_LEN;
    while (pkts_expected - pkts_received >= 3) @(posedge ulpi_clk);  // Room in buffer and queue
    tx_q.delete();
    tx_q.push_back(pid);
    for (i = 0; i < len; i++) tx_q.push_back(usb_pkg::usb_byte_t'($urandom_range(0, 255)));
    crc = ~crc16_over(1, len);
    tx_q.push_back(crc[7:0]);
    tx_q.push_back(crc[15:8]);
    assert (crc16_over(1, len + 2) == usb_pkg::CRC16_RESIDUE) else begin
      check_errors++;
      $display("CRC model missed the residue on a %0d byte payload", len);
    end
    if (corrupt) begin
      i = len + 1 + $urandom_range(0, 1);  // One bit of one CRC byte
      tx_q[i] = tx_q[i] ^ (8'h01 << $urandom_range(0, 7));
      if (is_data) bad_crc_sent++;
    end
    if (expect_out) begin
      for (i = 1; i <= len; i++) exp_q.push_back({i == len, tx_q[i]});
      pkts_expected++;
    end
    errs_before = crc_err_cnt;
    phy_send();
    pkts_sent++;
    assert (crc_err_cnt - errs_before == int'(is_data && corrupt)) else begin
      check_errors++;
      $display("error at %0t: %0d crc_error_o pulses for PID %h", $time,
               crc_err_cnt - errs_before, pid);
    end
  endtask

  always @(posedge ulpi_clk) begin
    if (bp_mode) blko_tready_i <= $urandom_range(0, 1);
    else blko_tready_i <= 1'b1;
  end

  // Monitor samples mid cycle and the transfer completes on the next rising edge
  always @(negedge ulpi_clk) begin
    if (crc_error_o) crc_err_cnt++;
    if (blko_tvalid_o && blko_tready_i) begin
      bytes_received++;
      assert (exp_q.size() != 0) else begin
        stream_errors++;
        $display("error at %0t: unexpected output byte %h", $time, blko_tdata_o);
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert ({blko_tlast_o, blko_tdata_o} == exp_word) else begin
          stream_errors++;
          $display("error at %0t: got %h tlast %b, expected %h tlast %b", $time,
                   blko_tdata_o, blko_tlast_o, exp_word[7:0], exp_word[8]);
        end
        if (exp_word[8]) pkts_received++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ulpi_clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    report_counts();
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int i;
    void'($urandom(SEED));
    rst_n_i     <= 1'b0;
    ulpi_dir_i  <= 1'b0;
    ulpi_nxt_i  <= 1'b0;
    ulpi_data_i <= '0;
    repeat (RESET_CYCLES) @(posedge ulpi_clk);
    rst_n_i <= 1'b1;
    check_reset_sequence();
    for (i = 0; i < N_GOOD; i++) begin  // Shortest and longest payloads first
      run_packet(pid_byte(i[0] ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0),
                 i == 0 ? 1 : (i == 1 ? MAX_LEN : $urandom_range(1, MAX_LEN)), 1'b0);
    end
    for (i = 0; i < N_CRC_BAD; i++) begin
      run_packet(pid_byte(i[0] ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0),
                 $urandom_range(1, MAX_LEN), 1'b1);
    end
    run_packet(8'hE1, 0, 1'b0);  // OUT token with three bytes on the wire
    run_packet(8'hA5, 0, 1'b0);  // SOF
    run_packet(8'hD3, $urandom_range(1, MAX_LEN), 1'b0);
    run_packet(8'h5B, $urandom_range(1, MAX_LEN), 1'b1);
    bp_mode <= 1'b1;
    for (i = 0; i < N_BP; i++) begin
      run_packet(pid_byte(i[0] ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0),
                 $urandom_range(1, MAX_LEN), 1'b0);
    end
    while (pkts_received != pkts_expected) @(posedge ulpi_clk);
    bp_mode <= 1'b0;
    run_packet(pid_byte(usb_pkg::PID_DATA0), MAX_LEN + 1, 1'b0);
    run_packet(pid_byte(usb_pkg::PID_DATA1), $urandom_range(1, MAX_LEN), 1'b0);
    while (pkts_received != pkts_expected) @(posedge ulpi_clk);
    repeat (4) @(posedge ulpi_clk);
    assert (exp_q.size() == 0 && crc_err_cnt == bad_crc_sent) else begin
      check_errors++;
      $display("error at %0t: %0d bytes missing, %0d crc errors for %0d bad packets", $time,
               exp_q.size(), crc_err_cnt, bad_crc_sent);
    end
    report_counts();
    if (check_errors + stream_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
src/usb_pkg.sv
src/ulpi_reset.sv
src/ulpi_rx.sv
src/usb_pid_check.sv
src/usb_crc16.sv
src/usb_bulk_out.sv
src/usb_ulpi_core.sv
tests/tb_clock.sv
tests/usb_ulpi_core_sva.sv
tests/usb_ulpi_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = usb_ulpi_core_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = TESTBENCH FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
